// File: network_packet_generator.f
+incdir+src
src/pktgen_reg_pkg.sv
src/pktgen_pkt_pkg.sv
src/pktgen_csr.sv
src/pktgen_flow_table.sv
src/pktgen_shaper.sv
src/pktgen_framer.sv
src/network_packet_generator.sv
sim/network_packet_generator_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the packet generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f network_packet_generator.f \
    --top-module network_packet_generator_tb -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

// File: sim/network_packet_generator_tb.sv
/* Packet generator testbench
   Random flows under back-pressure, checked beat by beat against a reference model */

`include "pktgen_macros.svh"

module network_packet_generator_tb;
    localparam int BEAT = `PKTGEN_DATA_BYTES;
    // Longest run is 40 + 30 + 20 + 101 packets of at most 300 bytes
    localparam int TIMEOUT_CYCLES = 2 * (191 * 300) / BEAT + 20000;

    logic                      avmm_clk_ifc;
    logic                      rst;
    pktgen_reg_pkg::avmm_req_t avmm_req;
    pktgen_reg_pkg::reg_data_t avmm_readdata;
    logic                      avmm_readdatavalid;
    pktgen_pkt_pkg::beat_t     out_beat;
    logic                      out_valid;
    logic                      out_ready;

    // Reference flow table
    logic [47:0] fl_da [8];
    logic [47:0] fl_sa [8];
    logic [15:0] fl_et [8];
    int          fl_len [8];
    logic [7:0]  fl_fill [8];
    int          last_flow;

    int          m_flow, m_off;
    longint      m_pkts, m_bytes;
    int          errors, tests, failed_tests;
    int          cycles, valid_cycles;
    logic        hold_ready, held_valid;
    pktgen_pkt_pkg::beat_t held_beat;
    logic        shp_on;
    int          shp_pkts, shp_t0, shp_t1;
    longint      shp_bytes;

    network_packet_generator dut_i (
        .avmm_clk_ifc       ( avmm_clk_ifc       ),
        .rst                ( rst                ),
        .avmm_req           ( avmm_req           ),
        .avmm_readdata      ( avmm_readdata      ),
        .avmm_readdatavalid ( avmm_readdatavalid ),
        .out_beat           ( out_beat           ),
        .out_valid          ( out_valid          ),
        .out_ready          ( out_ready          )
    );

    always #4 avmm_clk_ifc = ~avmm_clk_ifc;

    always @(posedge avmm_clk_ifc) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, DUT stopped making progress", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // Roughly 70% ready unless held high
    always @(posedge avmm_clk_ifc) begin
        #1;
        out_ready = hold_ready ? 1'b1 : (($urandom % 10) < 7);
    end

    task automatic check_eq(string name, logic [63:0] got, logic [63:0] exp);
        assert (got == exp) else begin
            $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_true(logic cond, string msg);
        assert (cond) else begin
            $display("Error at %0t: %s", $time, msg);
            errors++;
        end
    endtask

    function automatic pktgen_pkt_pkg::beat_t expected_beat(int f, int off);
        pktgen_pkt_pkg::beat_t b;
        logic [111:0] hdr;
        int p;
        hdr = {fl_da[f], fl_sa[f], fl_et[f]};
        b = '0;
        b.tuser = f[2:0];
        b.tlast = (off + BEAT >= fl_len[f]);
        for (int i = 0; i < BEAT; i++) begin
            p = off + i;
            b.tkeep[i] = (p < fl_len[f]);
            if (p < 14) begin
                b.tdata[8*i +: 8] = hdr[8*(13-p) +: 8];
            end else if (p < fl_len[f]) begin
                b.tdata[8*i +: 8] = fl_fill[f];
            end
        end
        return b;
    endfunction

    ////////////////////
    // Output monitor and model
    always @(negedge avmm_clk_ifc) begin
        pktgen_pkt_pkg::beat_t exp;
        logic [63:0] mask;
        if (!rst) begin
            if (held_valid && !out_valid) begin
                check_true(1'b0, "valid dropped before ready");
            end
            if (out_valid) begin
                valid_cycles++;
                if (held_valid) begin
                    check_eq("stalled out_beat.tdata", 64'(out_beat.tdata),
                             64'(held_beat.tdata));
                    check_eq("stalled out_beat.tkeep", 64'(out_beat.tkeep),
                             64'(held_beat.tkeep));
                    check_eq("stalled out_beat.tlast", 64'(out_beat.tlast),
                             64'(held_beat.tlast));
                    check_eq("stalled out_beat.tuser", 64'(out_beat.tuser),
                             64'(held_beat.tuser));
                end
                if (out_ready) begin
                    exp = expected_beat(m_flow, m_off);
                    for (int i = 0; i < BEAT; i++) begin
                        mask[8*i +: 8] = {8{out_beat.tkeep[i]}};
                    end
                    check_eq("out_beat.tdata", out_beat.tdata & mask, exp.tdata);
                    check_eq("out_beat.tkeep", 64'(out_beat.tkeep), 64'(exp.tkeep));
                    check_eq("out_beat.tlast", 64'(out_beat.tlast), 64'(exp.tlast));
                    check_eq("out_beat.tuser", 64'(out_beat.tuser), 64'(exp.tuser));
                    if (shp_on && m_off == 0) begin
                        if (shp_pkts == 0) begin
                            shp_t0 = cycles;
                        end
                        if (shp_pkts == 100) begin
                            shp_t1 = cycles;
                        end
                        if (shp_pkts < 100) begin
                            shp_bytes += fl_len[m_flow];
                        end
                        shp_pkts++;
                    end
                    if (exp.tlast) begin
                        m_pkts++;
                        m_bytes += fl_len[m_flow];
                        m_flow = (m_flow >= last_flow) ? 0 : m_flow + 1;
                        m_off = 0;
                    end else begin
                        m_off += BEAT;
                    end
                    held_valid = 1'b0;
                end else begin
                    held_valid = 1'b1;
                    held_beat = out_beat;
                end
            end else begin
                held_valid = 1'b0;
            end
        end
    end

    task automatic reg_write(int addr, logic [31:0] data);
        @(posedge avmm_clk_ifc);
        #1;
        avmm_req = '{read: 1'b0, write: 1'b1, address: addr[4:0], writedata: data};
        @(posedge avmm_clk_ifc);
        #1;
        avmm_req = '0;
    endtask

    task automatic reg_read(int addr, output logic [31:0] data);
        @(posedge avmm_clk_ifc);
        #1;
        avmm_req = '{read: 1'b1, write: 1'b0, address: addr[4:0], writedata: '0};
        @(posedge avmm_clk_ifc);
        #1;
        avmm_req = '0;
        check_true(avmm_readdatavalid, "readdatavalid missing one cycle after read");
        data = avmm_readdata;
    endtask

    task automatic load_flow(int f);
        logic [133:0] def;
        logic [159:0] flat;
        fl_da[f]   = {$urandom, $urandom} & 48'hffff_ffff_ffff;
        fl_sa[f]   = {$urandom, $urandom} & 48'hffff_ffff_ffff;
        fl_et[f]   = 16'($urandom);
        fl_len[f]  = 64 + ($urandom % 237);
        fl_fill[f] = 8'($urandom);
        def  = {fl_da[f], fl_sa[f], fl_et[f], 14'(fl_len[f]), fl_fill[f]};
        flat = {def, 26'd0};
        for (int i = 0; i < 5; i++) begin
            reg_write(8 + i, flat[32*(4-i) +: 32]);
        end
        reg_write(2, 32'(f << 4) | 32'd1);
    endtask

    task automatic start_tx(logic [31:0] con);
        m_flow = 0;
        m_off  = 0;
        reg_write(0, con);
    endtask

    task automatic stop_and_drain();
        reg_write(0, 32'd0);
        repeat (3) @(posedge avmm_clk_ifc);
        do begin
            @(posedge avmm_clk_ifc);
            #1;
        end while (out_valid);
        check_true(m_off == 0, "transmission stopped inside a packet");
    endtask

    task automatic report(string name, int err_before);
        tests++;
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] wd;
        logic [63:0] cnt;
        longint      base;
        int          vbase, eb;
        real         r;
        avmm_clk_ifc = 1'b0;
        rst = 1'b1;
        avmm_req = '0;
        out_ready = 1'b0;
        hold_ready = 1'b0;
        held_valid = 1'b0;
        shp_on = 1'b0;
        {m_flow, m_off, m_pkts, m_bytes, errors, tests, failed_tests} = '0;
        {valid_cycles, shp_pkts, shp_t0, shp_t1, shp_bytes} = '0;
        rd = $urandom(46);
        repeat (10) @(posedge avmm_clk_ifc);
        #1;
        rst = 1'b0;

        // 1. Register readback
        eb = errors;
        reg_write(0, 32'h0000_1230);
        reg_read(0, rd);
        check_eq("TX_CON", 64'(rd), 64'h1230);
        reg_write(1, 32'h0001_8000);
        reg_read(1, rd);
        check_eq("SHAPER_CON", 64'(rd), 64'h18000);
        reg_write(1, 32'd0);
        reg_write(0, 32'd0);
        for (int i = 0; i < 5; i++) begin
            wd = $urandom;
            reg_write(8 + i, wd);
            reg_read(8 + i, rd);
            check_eq("FLOW_DEF_DATA", 64'(rd), 64'(wd));
        end
        report("register readback", eb);

        for (int f = 0; f < 6; f++) begin
            load_flow(f);
        end
        last_flow = 5;
        reg_write(2, 32'(5 << 16));

        // 2. Frame content under back-pressure
        eb = errors;
        base = m_pkts;
        start_tx(32'd1);
        while (m_pkts < base + 40) @(posedge avmm_clk_ifc);
        stop_and_drain();
        report("frame content", eb);

        // 3. Finite transmission of 30 packets
        eb = errors;
        base = m_pkts;
        start_tx(32'((30 << 4) | 3));
        while (m_pkts < base + 30) @(posedge avmm_clk_ifc);
        vbase = valid_cycles;
        repeat (500) @(posedge avmm_clk_ifc);
        check_eq("finite packet count", 64'(m_pkts - base), 64'd30);
        check_true(valid_cycles == vbase, "valid seen after finite count reached");
        reg_write(0, 32'd0);
        report("finite transmission", eb);

        // 4. Statistics counters
        eb = errors;
        reg_read(3, rd);
        cnt[31:0] = rd;
        reg_read(4, rd);
        cnt[63:32] = rd;
        check_eq("GEN_TX_PKT_CNT", cnt, 64'(m_pkts));
        reg_read(5, rd);
        cnt[31:0] = rd;
        reg_read(6, rd);
        cnt[63:32] = rd;
        check_eq("GEN_TX_BYTE_CNT", cnt, 64'(m_bytes));
        report("counters", eb);

        // 5. Disable mid-stream
        eb = errors;
        base = m_pkts;
        start_tx(32'd1);
        while (m_pkts < base + 5) @(posedge avmm_clk_ifc);
        repeat ($urandom % 40) @(posedge avmm_clk_ifc);
        stop_and_drain();
        vbase = valid_cycles;
        repeat (300) @(posedge avmm_clk_ifc);
        check_true(valid_cycles == vbase, "valid seen after disable");
        report("stop on disable", eb);

        // 6. Shaper at 2.5 bytes per cycle
        eb = errors;
        reg_write(1, 32'd163840);
        hold_ready = 1'b1;
        shp_on = 1'b1;
        start_tx(32'd1);
        while (shp_pkts <= 100) @(posedge avmm_clk_ifc);
        stop_and_drain();
        shp_on = 1'b0;
        hold_ready = 1'b0;
        reg_write(1, 32'd0);
        r = real'(shp_bytes) / real'(shp_t1 - shp_t0);
        $display("measured rate %f bytes per cycle", r);
        check_true(r > 2.45 && r < 2.55, "shaped rate outside 2% of 2.5 bytes per cycle");
        report("shaper", eb);

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src/network_packet_generator.sv
/* Ethernet test packet generator top
   Register block, flow table, rate shaper and framer on one clock */

module network_packet_generator (
    input  logic                      avmm_clk_ifc,
    input  logic                      rst,
    input  pktgen_reg_pkg::avmm_req_t avmm_req,
    output pktgen_reg_pkg::reg_data_t avmm_readdata,
    output logic                      avmm_readdatavalid,
    output pktgen_pkt_pkg::beat_t     out_beat,
    output logic                      out_valid,
    input  logic                      out_ready
);
    pktgen_pkt_pkg::tx_event_t tx_event;
    logic                      tx_enable;
    logic                      tx_finite;
    logic [27:0]               tx_count;
    pktgen_pkt_pkg::flow_id_t  last_flow;
    pktgen_pkt_pkg::rate_t     rate;
    logic                      def_wr;
    pktgen_pkt_pkg::flow_id_t  def_wr_id;
    pktgen_pkt_pkg::flow_def_t def_wr_data;
    logic                      rd_req;
    pktgen_pkt_pkg::flow_id_t  rd_id;
    logic                      rd_grant;
    pktgen_pkt_pkg::flow_def_t rd_data;
    logic                      start_req;
    pktgen_pkt_pkg::pkt_len_t  start_len;
    logic                      admit;

    pktgen_csr csr_i (
        .avmm_clk_ifc  ( avmm_clk_ifc       ),
        .rst           ( rst                ),
        .req           ( avmm_req           ),
        .readdata      ( avmm_readdata      ),
        .readdatavalid ( avmm_readdatavalid ),
        .tx_event      ( tx_event           ),
        .tx_enable     ( tx_enable          ),
        .tx_finite     ( tx_finite          ),
        .tx_count      ( tx_count           ),
        .last_flow     ( last_flow          ),
        .rate          ( rate               ),
        .def_wr        ( def_wr             ),
        .def_wr_id     ( def_wr_id          ),
        .def_wr_data   ( def_wr_data        )
    );

    pktgen_flow_table flow_table_i (
        .avmm_clk_ifc ( avmm_clk_ifc ),
        .wr           ( def_wr       ),
        .wr_id        ( def_wr_id    ),
        .wr_data      ( def_wr_data  ),
        .rd_req       ( rd_req       ),
        .rd_id        ( rd_id        ),
        .rd_grant     ( rd_grant     ),
        .rd_data      ( rd_data      )
    );

    pktgen_shaper shaper_i (
        .avmm_clk_ifc ( avmm_clk_ifc ),
        .rst          ( rst          ),
        .rate         ( rate         ),
        .start_req    ( start_req    ),
        .start_len    ( start_len    ),
        .admit        ( admit        )
    );

    pktgen_framer framer_i (
        .avmm_clk_ifc ( avmm_clk_ifc ),
        .rst          ( rst          ),
        .tx_enable    ( tx_enable    ),
        .tx_finite    ( tx_finite    ),
        .tx_count     ( tx_count     ),
        .last_flow    ( last_flow    ),
        .rd_req       ( rd_req       ),
        .rd_id        ( rd_id        ),
        .rd_grant     ( rd_grant     ),
        .rd_data      ( rd_data      ),
        .start_req    ( start_req    ),
        .start_len    ( start_len    ),
        .admit        ( admit        ),
        .out_beat     ( out_beat     ),
        .out_valid    ( out_valid    ),
        .out_ready    ( out_ready    ),
        .tx_event     ( tx_event     )
    );

endmodule

// File: src/pktgen_framer.sv
/* Packet framer
   Walks the flows round robin, waits for shaper admission and streams the beats */

`include "pktgen_macros.svh"

module pktgen_framer (
    input  logic                      avmm_clk_ifc,
    input  logic                      rst,
    input  logic                      tx_enable,
    input  logic                      tx_finite,
    input  logic [27:0]               tx_count,
    input  pktgen_pkt_pkg::flow_id_t  last_flow,
    output logic                      rd_req,
    output pktgen_pkt_pkg::flow_id_t  rd_id,
    input  logic                      rd_grant,
    input  pktgen_pkt_pkg::flow_def_t rd_data,
    output logic                      start_req,
    output pktgen_pkt_pkg::pkt_len_t  start_len,
    input  logic                      admit,
    output pktgen_pkt_pkg::beat_t     out_beat,
    output logic                      out_valid,
    input  logic                      out_ready,
    output pktgen_pkt_pkg::tx_event_t tx_event
);
    localparam int BEAT_BYTES = `PKTGEN_DATA_BYTES;
    localparam int HDR_BYTES  = 14;
    localparam int CNT_W      = $bits(pktgen_pkt_pkg::tx_event_t) - 2;

    pktgen_pkt_pkg::frame_state_e state;
    pktgen_pkt_pkg::flow_id_t     flow_ptr;
    pktgen_pkt_pkg::flow_id_t     cur_id;
    pktgen_pkt_pkg::pkt_len_t     byte_off;
    logic [27:0]                  pkt_sent;
    logic                         enable_q;
    logic                         done;
    logic [14:0]                  next_off;
    logic [8*HDR_BYTES-1:0]       hdr;

    assign done     = tx_finite && (pkt_sent >= tx_count);
    assign next_off = {1'b0, byte_off} + 15'(BEAT_BYTES);
    assign hdr      = {rd_data.mac_da, rd_data.mac_sa, rd_data.ether_type};

    assign rd_req    = (state == pktgen_pkt_pkg::FETCH);
    assign rd_id     = flow_ptr;
    assign start_req = (state == pktgen_pkt_pkg::WAIT_CREDIT) && tx_enable;
    assign start_len = rd_data.pkt_len;
    assign out_valid = (state == pktgen_pkt_pkg::SEND);

    ////////////////////
    // Beat builder
    always_comb begin
        logic [14:0] pos;
        out_beat.tuser = cur_id;
        out_beat.tlast = next_off >= {1'b0, rd_data.pkt_len};
        for (int i = 0; i < BEAT_BYTES; i++) begin
            pos = {1'b0, byte_off} + 15'(i);
            out_beat.tkeep[i] = pos < {1'b0, rd_data.pkt_len};
            if (pos < 15'(HDR_BYTES)) begin
                out_beat.tdata[8*i +: 8] = hdr[8*(HDR_BYTES-1-int'(pos[3:0])) +: 8];
            end else begin
                out_beat.tdata[8*i +: 8] = rd_data.payload_value;
            end
        end
    end

    assign tx_event.valid = out_valid && out_ready;
    assign tx_event.last  = out_beat.tlast;
    assign tx_event.bytes = CNT_W'($countones(out_beat.tkeep));

    ////////////////////
    // Sequencer FSM
    always_ff @(posedge avmm_clk_ifc) begin
        if (rst) begin
            state    <= pktgen_pkt_pkg::IDLE;
            flow_ptr <= '0;
            byte_off <= '0;
            pkt_sent <= '0;
            enable_q <= 1'b0;
        end else begin
            enable_q <= tx_enable;
            case (state)
                pktgen_pkt_pkg::IDLE: begin
                    if (tx_enable && enable_q && !done) begin
                        state <= pktgen_pkt_pkg::FETCH;
                    end
                end
                pktgen_pkt_pkg::FETCH: begin
                    if (rd_grant) begin
                        state    <= pktgen_pkt_pkg::WAIT_CREDIT;
                        flow_ptr <= (flow_ptr >= last_flow) ? '0 : flow_ptr + 1'b1;
                    end
                end
                pktgen_pkt_pkg::WAIT_CREDIT: begin
                    byte_off <= '0;
                    // Nothing sent yet, so a disable drops this packet
                    if (!tx_enable) begin
                        state <= pktgen_pkt_pkg::IDLE;
                    end else if (admit) begin
                        state <= pktgen_pkt_pkg::SEND;
                    end
                end
                pktgen_pkt_pkg::SEND: begin
                    if (out_ready) begin
                        byte_off <= next_off[13:0];
                        if (out_beat.tlast) begin
                            state <= pktgen_pkt_pkg::IDLE;
                            if (tx_finite) begin
                                pkt_sent <= pkt_sent + 28'd1;
                            end
                        end
                    end
                end
                default: state <= pktgen_pkt_pkg::IDLE;
            endcase
            // Fresh start of transmission
            if (tx_enable && !enable_q) begin
                flow_ptr <= '0;
                pkt_sent <= '0;
            end
        end
    end

    always_ff @(posedge avmm_clk_ifc) begin
        if (rd_grant) begin
            cur_id <= flow_ptr;
        end
    end

endmodule

// File: src/pktgen_shaper.sv
/* Byte-credit rate shaper
   Admits a packet start when the credit is not negative, then charges its length */

`include "pktgen_macros.svh"

module pktgen_shaper (
    input  logic                     avmm_clk_ifc,
    input  logic                     rst,
    input  pktgen_pkt_pkg::rate_t    rate,
    input  logic                     start_req,
    input  pktgen_pkt_pkg::pkt_len_t start_len,
    output logic                     admit
);
    localparam int FRAC     = `PKTGEN_RATE_FRAC_BITS;
    localparam int LEN_W    = $bits(pktgen_pkt_pkg::pkt_len_t);
    localparam int CREDIT_W = $bits(pktgen_pkt_pkg::rate_t) + 2;
    localparam int PAD_W    = CREDIT_W - LEN_W - FRAC;

    // Largest packet length in credit units
    localparam logic signed [CREDIT_W-1:0] CREDIT_CAP =
        $signed({{PAD_W{1'b0}}, {LEN_W{1'b1}}, {FRAC{1'b0}}});

    logic signed [CREDIT_W-1:0] credit;
    logic signed [CREDIT_W-1:0] credit_add;
    logic signed [CREDIT_W-1:0] credit_next;

    assign admit = start_req && (rate == '0 || !credit[CREDIT_W-1]);

    always_comb begin
        credit_add = credit + $signed({2'b00, rate});
        if (admit) begin
            credit_add = credit_add - $signed({{PAD_W{1'b0}}, start_len, {FRAC{1'b0}}});
        end
        credit_next = (credit_add > CREDIT_CAP) ? CREDIT_CAP : credit_add;
    end

    always_ff @(posedge avmm_clk_ifc) begin
        if (rst) begin
            credit <= '0;
        end else if (rate == '0) begin
            // Bucket starts empty when shaping is switched on
            credit <= '0;
        end else begin
            credit <= credit_next;
        end
    end

endmodule

// File: src/pktgen_flow_table.sv
/* Single-port flow definition memory
   Register writes take the port first, framer reads get it when it is free */

`include "pktgen_macros.svh"

module pktgen_flow_table (
    input  logic                      avmm_clk_ifc,
    input  logic                      wr,
    input  pktgen_pkt_pkg::flow_id_t  wr_id,
    input  pktgen_pkt_pkg::flow_def_t wr_data,
    input  logic                      rd_req,
    input  pktgen_pkt_pkg::flow_id_t  rd_id,
    output logic                      rd_grant,
    output pktgen_pkt_pkg::flow_def_t rd_data
);
    pktgen_pkt_pkg::flow_def_t mem [`PKTGEN_NUM_FLOWS];
    pktgen_pkt_pkg::flow_id_t  port_id;

    ////////////////////
    // Arbiter

    // Fixed priority where a write never waits
    assign rd_grant = rd_req && !wr;
    assign port_id  = wr ? wr_id : rd_id;

    ////////////////////
    // Memory port
    always_ff @(posedge avmm_clk_ifc) begin
        if (wr) begin
            mem[port_id] <= wr_data;
        end
        // Held until the next grant
        if (rd_grant) begin
            rd_data <= mem[port_id];
        end
    end

endmodule

// File: src/pktgen_csr.sv
/* Generator register block
   Control registers, flow definition staging and the 64-bit transmit counters */

`include "pktgen_macros.svh"

module pktgen_csr (
    input  logic                      avmm_clk_ifc,
    input  logic                      rst,
    input  pktgen_reg_pkg::avmm_req_t req,
    output pktgen_reg_pkg::reg_data_t readdata,
    output logic                      readdatavalid,
    input  pktgen_pkt_pkg::tx_event_t tx_event,
    output logic                      tx_enable,
    output logic                      tx_finite,
    output logic [27:0]               tx_count,
    output pktgen_pkt_pkg::flow_id_t  last_flow,
    output pktgen_pkt_pkg::rate_t     rate,
    output logic                      def_wr,
    output pktgen_pkt_pkg::flow_id_t  def_wr_id,
    output pktgen_pkt_pkg::flow_def_t def_wr_data
);
    localparam int WORDS = `PKTGEN_FLOW_DEF_WORDS;

    pktgen_reg_pkg::reg_data_t tx_con;
    pktgen_reg_pkg::reg_data_t stage [WORDS];
    logic [32*WORDS-1:0]       stage_flat;
    logic [63:0]               pkt_cnt;
    logic [63:0]               byte_cnt;
    logic [31:0]               pkt_cnt_hi;
    logic [31:0]               byte_cnt_hi;
    logic                      stage_hit;
    logic [2:0]                stage_idx;

    assign tx_enable = tx_con[0];
    assign tx_finite = tx_con[1];
    assign tx_count  = tx_con[31:4];

    // Data words sit at 8..12, so the low address bits index them
    assign stage_hit = (req.address >= pktgen_reg_pkg::ADDR_FLOW_DEF_DATA) &&
                       (req.address < pktgen_reg_pkg::ADDR_FLOW_DEF_DATA + WORDS);
    assign stage_idx = req.address[2:0];

    // Word 0 is the top of the definition and the unused bits sit at the bottom
    always_comb begin
        for (int i = 0; i < WORDS; i++) begin
            stage_flat[32*(WORDS-1-i) +: 32] = stage[i];
        end
    end
    assign def_wr_data = stage_flat[32*WORDS-1 -: $bits(pktgen_pkt_pkg::flow_def_t)];

    ////////////////////
    // Control and counters
    always_ff @(posedge avmm_clk_ifc) begin
        if (rst) begin
            tx_con        <= '0;
            rate          <= '0;
            last_flow     <= '0;
            def_wr        <= 1'b0;
            readdatavalid <= 1'b0;
            pkt_cnt       <= '0;
            byte_cnt      <= '0;
            pkt_cnt_hi    <= '0;
            byte_cnt_hi   <= '0;
        end else begin
            def_wr        <= 1'b0;
            readdatavalid <= req.read;
            if (req.write) begin
                case (req.address)
                    pktgen_reg_pkg::ADDR_TX_CON:     tx_con <= req.writedata;
                    pktgen_reg_pkg::ADDR_SHAPER_CON: rate   <= req.writedata;
                    pktgen_reg_pkg::ADDR_FLOW_DEF_CON: begin
                        if (req.writedata[0]) begin
                            def_wr <= 1'b1;
                        end else begin
                            last_flow <= req.writedata[18:16];
                        end
                    end
                    default: ;
                endcase
            end
            if (tx_event.valid) begin
                byte_cnt <= byte_cnt + 64'(tx_event.bytes);
                if (tx_event.last) begin
                    pkt_cnt <= pkt_cnt + 64'd1;
                end
            end
            // Upper halves frozen by the low word read
            if (req.read && req.address == pktgen_reg_pkg::ADDR_GEN_TX_PKT_CNT0) begin
                pkt_cnt_hi <= pkt_cnt[63:32];
            end
            if (req.read && req.address == pktgen_reg_pkg::ADDR_GEN_TX_BYTE_CNT0) begin
                byte_cnt_hi <= byte_cnt[63:32];
            end
        end
    end

    ////////////////////
    // Staging and read data
    always_ff @(posedge avmm_clk_ifc) begin
        if (req.write && stage_hit) begin
            stage[stage_idx] <= req.writedata;
        end
        if (req.write && req.address == pktgen_reg_pkg::ADDR_FLOW_DEF_CON) begin
            def_wr_id <= req.writedata[6:4];
        end
        readdata <= '0;
        case (req.address)
            pktgen_reg_pkg::ADDR_TX_CON:           readdata <= tx_con;
            pktgen_reg_pkg::ADDR_SHAPER_CON:       readdata <= rate;
            pktgen_reg_pkg::ADDR_FLOW_DEF_CON:     readdata <= {13'd0, last_flow, 16'd0};
            pktgen_reg_pkg::ADDR_GEN_TX_PKT_CNT0:  readdata <= pkt_cnt[31:0];
            pktgen_reg_pkg::ADDR_GEN_TX_PKT_CNT1:  readdata <= pkt_cnt_hi;
            pktgen_reg_pkg::ADDR_GEN_TX_BYTE_CNT0: readdata <= byte_cnt[31:0];
            pktgen_reg_pkg::ADDR_GEN_TX_BYTE_CNT1: readdata <= byte_cnt_hi;
            default: begin
                if (stage_hit) begin
                    readdata <= stage[stage_idx];
                end
            end
        endcase
    end

endmodule

// File: src/pktgen_pkt_pkg.sv
/* Packet side types for flow definitions, stream beats, transmit events and framer states */

`include "pktgen_macros.svh"

package pktgen_pkt_pkg;

    typedef logic [$clog2(`PKTGEN_NUM_FLOWS)-1:0] flow_id_t;
    typedef logic [13:0]                          pkt_len_t;
    typedef logic [31:0]                          rate_t;

    typedef struct packed {
        logic [47:0] mac_da;
        logic [47:0] mac_sa;
        logic [15:0] ether_type;
        pkt_len_t    pkt_len;
        logic [7:0]  payload_value;
    } flow_def_t;

    typedef struct packed {
        logic [8*`PKTGEN_DATA_BYTES-1:0] tdata;
        logic [`PKTGEN_DATA_BYTES-1:0]   tkeep;
        logic                            tlast;
        flow_id_t                        tuser;
    } beat_t;

    // One accepted output beat
    typedef struct packed {
        logic                                   valid;
        logic                                   last;
        logic [$clog2(`PKTGEN_DATA_BYTES+1)-1:0] bytes;
    } tx_event_t;

    typedef enum logic [1:0] {IDLE, FETCH, WAIT_CREDIT, SEND} frame_state_e;

endpackage

// File: src/pktgen_reg_pkg.sv
/* Register port types and the word address map of the generator */

`include "pktgen_macros.svh"

package pktgen_reg_pkg;

    typedef logic [`PKTGEN_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]               reg_data_t;

    // One Avalon-MM request without waitrequest or burst
    typedef struct packed {
        logic      read;
        logic      write;
        reg_addr_t address;
        reg_data_t writedata;
    } avmm_req_t;

    typedef enum reg_addr_t {
        ADDR_TX_CON           = 0,
        ADDR_SHAPER_CON       = 1,
        ADDR_FLOW_DEF_CON     = 2,
        ADDR_GEN_TX_PKT_CNT0  = 3,
        ADDR_GEN_TX_PKT_CNT1  = 4,
        ADDR_GEN_TX_BYTE_CNT0 = 5,
        ADDR_GEN_TX_BYTE_CNT1 = 6,
        // First of the staged flow definition words
        ADDR_FLOW_DEF_DATA    = 8
    } reg_addr_e;

endpackage

// File: src/pktgen_macros.svh
/* Packet generator build constants
   Flow table size, beat width, register map size and shaper precision */

`ifndef PKTGEN_MACROS_SVH
`define PKTGEN_MACROS_SVH

// Flow table entries
`define PKTGEN_NUM_FLOWS 8

// Bytes per output beat
`define PKTGEN_DATA_BYTES 8

// 32-bit staging words per flow definition
`define PKTGEN_FLOW_DEF_WORDS 5

// Register word address width
`define PKTGEN_ADDR_W 5

// Shaper rate is bytes per cycle in fixed point
`define PKTGEN_RATE_FRAC_BITS 16

`endif
